/* hw/eth_settings.svh */
`ifndef ETH_SETTINGS_SVH
`define ETH_SETTINGS_SVH

// Stream width in bytes
// Must divide the header length, so 1, 2, 7 or 14
`define ETH_AXIS_BYTES 2

// Destination MAC, source MAC and ethertype
`define ETH_HDR_BYTES 14

// Beats needed to send the header on the stream
`define ETH_HDR_BEATS (`ETH_HDR_BYTES / `ETH_AXIS_BYTES)

// Header beat index width of at least one bit
`define ETH_HDR_IDX_W ((`ETH_HDR_BEATS > 1) ? $clog2(`ETH_HDR_BEATS) : 1)

`endif

/* hw/axis_pkg.sv */
`include "eth_settings.svh"

package axis_pkg;

// Byte lanes of one beat with lane 0 in bits [7:0]
typedef logic [8*`ETH_AXIS_BYTES-1:0] axis_data_t;

// One bit per byte lane
typedef logic [`ETH_AXIS_BYTES-1:0] axis_keep_t;

// One beat of the byte stream
typedef struct packed {
	axis_data_t tdata;
	axis_keep_t tkeep;
	logic       tlast;
} axis_beat_t;

endpackage

/* hw/eth_pkg.sv */
`include "eth_settings.svh"

package eth_pkg;

import axis_pkg::*;

localparam int ETH_MAC_BYTES = 6;

// Header fields as they arrive on the sideband
typedef struct packed {
	logic [8*ETH_MAC_BYTES-1:0] dst_mac;
	logic [8*ETH_MAC_BYTES-1:0] src_mac;
	logic [15:0]                ethertype;
} eth_hdr_t;

// Header bytes in wire order with element 0 going out first
typedef logic [`ETH_HDR_BYTES-1:0][7:0] eth_hdr_bytes_t;

// Index of the header beat being sent
typedef logic [`ETH_HDR_IDX_W-1:0] eth_hdr_idx_t;

// Payload beat plus the header of the frame it belongs to
typedef struct packed {
	axis_beat_t stream;
	eth_hdr_t   hdr;
} eth_in_beat_t;

typedef enum logic [0:0] {
	ST_HEADER  = 1'b0,
	ST_PAYLOAD = 1'b1
} eth_framer_state_t;

endpackage

/* hw/axis_reg_slice.sv */
`timescale 1ns/100ps

module axis_reg_slice
	import axis_pkg::*;
#(
	parameter type T = axis_beat_t
) (
	input  logic clk,
	input  logic sresetn,

	input  logic s_valid_i,
	input  T     s_data_i,
	output logic s_ready_o,

	output logic m_valid_o,
	output T     m_data_o,
	input  logic m_ready_i
);

// Input side opens one cycle after reset is released
logic open_q;
logic full_q;
T     data_q;

// Accept when empty, or when the held beat leaves this cycle
assign s_ready_o = open_q && (!full_q || m_ready_i);
assign m_valid_o = full_q;
assign m_data_o  = data_q;

always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		open_q <= 1'b0;
		full_q <= 1'b0;
	end
	else
	begin
		open_q <= 1'b1;
		if (s_ready_o)
		begin
			full_q <= s_valid_i;
		end
	end
end

always_ff @(posedge clk)
begin
	if (s_valid_i && s_ready_o)
	begin
		data_q <= s_data_i;
	end
end

// A stalled beat must still be there, unchanged, on the next cycle
a_hold_stable: assert property (@(posedge clk) disable iff (!sresetn)
	(m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_data_o)))
	else $error("axis_reg_slice: held beat changed while stalled");

endmodule

/* hw/eth_framer_fsm.sv */
`timescale 1ns/100ps

module eth_framer_fsm
	import eth_pkg::*;
(
	input  logic              clk,
	input  logic              sresetn,

	// Header beat accepted downstream
	input  logic              hdr_fire_i,
	// Current header beat is the last one
	input  logic              hdr_last_i,
	// Final payload beat of the frame accepted downstream
	input  logic              pay_last_fire_i,

	output eth_framer_state_t state_o
);

eth_framer_state_t state_q;
eth_framer_state_t state_d;

assign state_o = state_q;

always_comb
begin
	state_d = state_q;
	case (state_q)
		ST_HEADER:
		begin
			// Whole header sent so the payload follows
			if (hdr_fire_i && hdr_last_i)
			begin
				state_d = ST_PAYLOAD;
			end
		end
		ST_PAYLOAD:
		begin
			// Frame done so the next one starts with its header
			if (pay_last_fire_i)
			begin
				state_d = ST_HEADER;
			end
		end
		default:
		begin
			state_d = ST_HEADER;
		end
	endcase
end

always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		state_q <= ST_HEADER;
	end
	else
	begin
		state_q <= state_d;
	end
end

// The builder may only emit header beats while in the header state
a_hdr_in_header: assert property (@(posedge clk) disable iff (!sresetn)
	hdr_fire_i |-> (state_q == ST_HEADER))
	else $error("eth_framer_fsm: header beat sent during payload");

// And the frame can only end once its header is out
a_last_in_payload: assert property (@(posedge clk) disable iff (!sresetn)
	pay_last_fire_i |-> (state_q == ST_PAYLOAD))
	else $error("eth_framer_fsm: payload end seen during header");

endmodule

/* hw/eth_hdr_beat_cnt.sv */
`timescale 1ns/100ps
`include "eth_settings.svh"

module eth_hdr_beat_cnt
	import eth_pkg::*;
(
	input  logic         clk,
	input  logic         sresetn,

	input  logic         hdr_fire_i,

	output eth_hdr_idx_t beat_idx_o,
	output logic         hdr_last_o
);

localparam eth_hdr_idx_t LAST_IDX = eth_hdr_idx_t'(`ETH_HDR_BEATS - 1);

eth_hdr_idx_t idx_q;

assign beat_idx_o = idx_q;
assign hdr_last_o = (idx_q == LAST_IDX);

always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		idx_q <= '0;
	end
	else if (hdr_fire_i)
	begin
		// Wrap so the next frame starts at its first header beat
		if (hdr_last_o)
		begin
			idx_q <= '0;
		end
		else
		begin
			idx_q <= idx_q + 1'b1;
		end
	end
end

a_idx_range: assert property (@(posedge clk) disable iff (!sresetn)
	int'(beat_idx_o) < `ETH_HDR_BEATS)
	else $error("eth_hdr_beat_cnt: header beat index out of range");

endmodule

/* hw/eth_beat_builder.sv */
`timescale 1ns/100ps
`include "eth_settings.svh"

module eth_beat_builder
	import axis_pkg::*;
	import eth_pkg::*;
(
	input  eth_framer_state_t state_i,
	input  eth_hdr_idx_t      beat_idx_i,

	// Head of the input slice
	input  logic              head_valid_i,
	input  eth_in_beat_t      head_beat_i,
	output logic              head_ready_o,

	// Towards the output slice
	input  logic              out_ready_i,
	output logic              out_valid_o,
	output axis_beat_t        out_beat_o,

	output logic              hdr_fire_o,
	output logic              pay_last_fire_o
);

// Header must split into whole beats
if ((`ETH_HDR_BYTES % `ETH_AXIS_BYTES) != 0)
begin : g_bad_width
	$error("eth_beat_builder: ETH_AXIS_BYTES must divide the header length");
end

logic           in_header;
eth_hdr_bytes_t hdr_bytes;
axis_data_t     hdr_data;

assign in_header = (state_i == ST_HEADER);

// MACs and ethertype go out most significant byte first
always_comb
begin
	for (int i = 0; i < ETH_MAC_BYTES; i++)
	begin
		hdr_bytes[i]                 = head_beat_i.hdr.dst_mac[8*(ETH_MAC_BYTES-1-i) +: 8];
		hdr_bytes[ETH_MAC_BYTES + i] = head_beat_i.hdr.src_mac[8*(ETH_MAC_BYTES-1-i) +: 8];
	end
	hdr_bytes[2*ETH_MAC_BYTES]     = head_beat_i.hdr.ethertype[15:8];
	hdr_bytes[2*ETH_MAC_BYTES + 1] = head_beat_i.hdr.ethertype[7:0];
end

// Lane j of header beat n carries wire byte n*width + j
always_comb
begin
	for (int j = 0; j < `ETH_AXIS_BYTES; j++)
	begin
		hdr_data[8*j +: 8] = hdr_bytes[int'(beat_idx_i) * `ETH_AXIS_BYTES + j];
	end
end

always_comb
begin
	out_valid_o  = head_valid_i;
	out_beat_o   = head_beat_i.stream;
	head_ready_o = 1'b0;
	if (in_header)
	begin
		// Head beat stays put while only its sideband is read
		out_beat_o.tdata = hdr_data;
		out_beat_o.tkeep = '1;
		out_beat_o.tlast = 1'b0;
	end
	else
	begin
		head_ready_o = out_ready_i;
	end
end

assign hdr_fire_o      = in_header && head_valid_i && out_ready_i;
assign pay_last_fire_o = !in_header && head_valid_i && out_ready_i
	&& head_beat_i.stream.tlast;

endmodule

/* hw/eth_tx_framer.sv */
`timescale 1ns/100ps

module eth_tx_framer
	import axis_pkg::*;
	import eth_pkg::*;
(
	input  logic         clk,
	input  logic         sresetn,

	// Payload stream with per-beat header sideband
	input  logic         in_valid_i,
	input  eth_in_beat_t in_beat_i,
	output logic         in_ready_o,

	// Header followed by payload
	output logic         out_valid_o,
	output axis_beat_t   out_beat_o,
	input  logic         out_ready_i
);

logic              head_valid;
logic              head_ready;
eth_in_beat_t      head_beat;

logic              bld_valid;
logic              bld_ready;
axis_beat_t        bld_beat;

eth_framer_state_t state;
eth_hdr_idx_t      beat_idx;
logic              hdr_last;
logic              hdr_fire;
logic              pay_last_fire;

axis_reg_slice #(
	.T(eth_in_beat_t)
) u_in_slice (
	.clk       (clk),
	.sresetn   (sresetn),
	.s_valid_i (in_valid_i),
	.s_data_i  (in_beat_i),
	.s_ready_o (in_ready_o),
	.m_valid_o (head_valid),
	.m_data_o  (head_beat),
	.m_ready_i (head_ready)
);

eth_framer_fsm u_fsm (
	.clk             (clk),
	.sresetn         (sresetn),
	.hdr_fire_i      (hdr_fire),
	.hdr_last_i      (hdr_last),
	.pay_last_fire_i (pay_last_fire),
	.state_o         (state)
);

eth_hdr_beat_cnt u_cnt (
	.clk        (clk),
	.sresetn    (sresetn),
	.hdr_fire_i (hdr_fire),
	.beat_idx_o (beat_idx),
	.hdr_last_o (hdr_last)
);

eth_beat_builder u_builder (
	.state_i         (state),
	.beat_idx_i      (beat_idx),
	.head_valid_i    (head_valid),
	.head_beat_i     (head_beat),
	.head_ready_o    (head_ready),
	.out_ready_i     (bld_ready),
	.out_valid_o     (bld_valid),
	.out_beat_o      (bld_beat),
	.hdr_fire_o      (hdr_fire),
	.pay_last_fire_o (pay_last_fire)
);

axis_reg_slice #(
	.T(axis_beat_t)
) u_out_slice (
	.clk       (clk),
	.sresetn   (sresetn),
	.s_valid_i (bld_valid),
	.s_data_i  (bld_beat),
	.s_ready_o (bld_ready),
	.m_valid_o (out_valid_o),
	.m_data_o  (out_beat_o),
	.m_ready_i (out_ready_i)
);

endmodule

/* dv/eth_tx_framer_tb.sv */
`timescale 1ns/100ps
`include "eth_settings.svh"

module eth_tx_framer_tb
	import axis_pkg::*;
	import eth_pkg::*;
();

localparam int BYTES = `ETH_AXIS_BYTES;

typedef logic [7:0] byte_q_t [$];

logic         clk;
logic         sresetn;
logic         in_valid_i;
eth_in_beat_t in_beat_i;
logic         in_ready_o;
logic         out_valid_o;
axis_beat_t   out_beat_o;
logic         out_ready_i;

integer       seed;
int           gap_pct;
int           stall_pct;
int           total_beats;
int           frames_total;
int           frames_done;
logic         in_frame;

// Beats waiting to be offered and the ones held back for the stress phase
eth_in_beat_t drv_q [$];
eth_in_beat_t later_q [$];

// Expected wire bytes of all frames in output order
logic [7:0]   exp_q [$];
int           exp_len [$];
string        exp_name [$];
logic [7:0]   got_q [$];

eth_tx_framer u_eth_tx_framer (
	.clk         (clk),
	.sresetn     (sresetn),
	.in_valid_i  (in_valid_i),
	.in_beat_i   (in_beat_i),
	.in_ready_o  (in_ready_o),
	.out_valid_o (out_valid_o),
	.out_beat_o  (out_beat_o),
	.out_ready_i (out_ready_i)
);

always #10 clk = ~clk;

task automatic abort_run(input string why);
	$display("%s", why);
	$display("Errors found");
	$fatal(1);
endtask

task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (exp !== act)
	begin
		abort_run($sformatf("FAIL %s expected %0h actual %0h", name, exp, act));
	end
endtask

// Wire order is dst MAC, src MAC and ethertype, all MSB first, then the payload
function automatic byte_q_t expected_bytes(input eth_hdr_t hdr, input byte_q_t payload);
	byte_q_t q;
	for (int i = 5; i >= 0; i--)
	begin
		q.push_back(hdr.dst_mac[8*i +: 8]);
	end
	for (int i = 5; i >= 0; i--)
	begin
		q.push_back(hdr.src_mac[8*i +: 8]);
	end
	q.push_back(hdr.ethertype[15:8]);
	q.push_back(hdr.ethertype[7:0]);
	foreach (payload[i])
	begin
		q.push_back(payload[i]);
	end
	return q;
endfunction

function automatic eth_hdr_t random_hdr();
	eth_hdr_t    h;
	logic [31:0] r0;
	logic [31:0] r1;
	logic [31:0] r2;
	logic [31:0] r3;
	r0 = $random(seed);
	r1 = $random(seed);
	r2 = $random(seed);
	r3 = $random(seed);
	h.dst_mac   = {r0, r1[15:0]};
	h.src_mac   = {r2, r1[31:16]};
	h.ethertype = r3[15:0];
	return h;
endfunction

// Splits a random payload into beats where only the tlast beat may be partial
task automatic add_frame(input string name, input eth_hdr_t hdr, input int n_bytes,
	input bit later);
	byte_q_t      payload;
	byte_q_t      exp;
	eth_in_beat_t beat;
	logic [31:0]  r;
	int           n_beats;
	for (int i = 0; i < n_bytes; i++)
	begin
		r = $random(seed);
		payload.push_back(r[7:0]);
	end
	exp = expected_bytes(hdr, payload);
	foreach (exp[i])
	begin
		exp_q.push_back(exp[i]);
	end
	exp_len.push_back(exp.size());
	exp_name.push_back(name);
	n_beats = (n_bytes + BYTES - 1) / BYTES;
	for (int b = 0; b < n_beats; b++)
	begin
		beat = '0;
		beat.hdr = hdr;
		for (int j = 0; j < BYTES; j++)
		begin
			if (b * BYTES + j < n_bytes)
			begin
				beat.stream.tdata[8*j +: 8] = payload[b * BYTES + j];
				beat.stream.tkeep[j] = 1'b1;
			end
		end
		beat.stream.tlast = (b == n_beats - 1);
		if (later)
			later_q.push_back(beat);
		else
			drv_q.push_back(beat);
	end
	total_beats += `ETH_HDR_BEATS + n_beats;
	frames_total++;
endtask

task automatic compare_frame(input axis_keep_t last_keep);
	string      name;
	int         n;
	int         rem;
	axis_keep_t keep;
	if (exp_len.size() == 0)
	begin
		abort_run("An output frame arrived when no frame was expected");
	end
	else
	begin
		name = exp_name.pop_front();
		n = exp_len.pop_front();
		check_eq({name, " length"}, n, got_q.size());
		for (int i = 0; i < n; i++)
		begin
			check_eq($sformatf("%s byte %0d", name, i), exp_q.pop_front(), got_q[i]);
		end
		// Header is a whole number of beats, so the tail lanes follow the length
		rem = n % BYTES;
		keep = (rem == 0) ? '1 : axis_keep_t'((1 << rem) - 1);
		check_eq({name, " last tkeep"}, keep, last_keep);
		got_q.delete();
		frames_done++;
	end
endtask

// Driver that holds a beat until it is taken
always @(posedge clk)
begin
	if (!sresetn)
	begin
		in_valid_i  <= 1'b0;
		out_ready_i <= 1'b0;
	end
	else
	begin
		if (in_valid_i && in_ready_o)
		begin
			void'(drv_q.pop_front());
		end
		if (!(in_valid_i && !in_ready_o))
		begin
			if (drv_q.size() > 0 && ({$random(seed)} % 100) >= gap_pct)
			begin
				in_valid_i <= 1'b1;
				in_beat_i  <= drv_q[0];
			end
			else
			begin
				in_valid_i <= 1'b0;
			end
		end
		out_ready_i <= ({$random(seed)} % 100) >= stall_pct;
	end
end

// Monitor that gathers kept lanes and compares at each tlast
always @(posedge clk)
begin
	if (sresetn)
	begin
		// Without stalls a frame must leave in consecutive cycles
		if (gap_pct == 0 && stall_pct == 0 && in_frame && !out_valid_o)
		begin
			abort_run("Output went idle in the middle of a frame with no stalls");
		end
		if (out_valid_o && out_ready_i)
		begin
			for (int j = 0; j < BYTES; j++)
			begin
				if (out_beat_o.tkeep[j])
					got_q.push_back(out_beat_o.tdata[8*j +: 8]);
			end
			if (out_beat_o.tlast)
			begin
				compare_frame(out_beat_o.tkeep);
				in_frame = 1'b0;
			end
			else
			begin
				check_eq("full tkeep before tlast", {BYTES{1'b1}}, out_beat_o.tkeep);
				in_frame = 1'b1;
			end
		end
	end
end

// Watchdog allowing eight cycles per beat plus some slack
initial
begin
	longint limit_ns;
	#1;
	limit_ns = longint'(total_beats) * 20 * 8 + 2000;
	#(limit_ns);
	abort_run($sformatf("Timeout: frames did not finish within %0d ns", limit_ns));
end

initial
begin
	eth_hdr_t h;
	seed         = 32'h9fd9_c44d;
	clk          = 1'b0;
	sresetn      = 1'b0;
	in_valid_i   = 1'b0;
	in_beat_i    = '0;
	out_ready_i  = 1'b0;
	gap_pct      = 0;
	stall_pct    = 0;
	total_beats  = 0;
	frames_total = 0;
	frames_done  = 0;
	in_frame     = 1'b0;

	h.dst_mac   = 48'h0011_2233_4455;
	h.src_mac   = 48'h6677_8899_aabb;
	h.ethertype = 16'h0800;
	add_frame("single_beat", h, BYTES, 1'b0);
	h.dst_mac   = 48'hffff_ffff_ffff;
	h.src_mac   = 48'h0a0b_0c0d_0e0f;
	h.ethertype = 16'h86dd;
	add_frame("partial_last", h, 4 * BYTES + ((BYTES > 1) ? BYTES - 1 : 1), 1'b0);
	for (int i = 0; i < 3; i++)
	begin
		add_frame("back_to_back", random_hdr(), 1 + ({$random(seed)} % 20), 1'b0);
	end
	for (int i = 0; i < 12; i++)
	begin
		add_frame("random_stall", random_hdr(), 1 + ({$random(seed)} % 40), 1'b1);
	end

	repeat (2) @(posedge clk);
	@(negedge clk);
	check_eq("reset out_valid_o", 0, out_valid_o);
	check_eq("reset in_ready_o", 0, in_ready_o);
	@(posedge clk);
	sresetn <= 1'b1;

	wait (frames_done == 5);
	// Switch to the stress phase between clock edges
	@(negedge clk);
	gap_pct   = 30;
	stall_pct = 40;
	while (later_q.size() > 0)
	begin
		drv_q.push_back(later_q.pop_front());
	end

	wait (frames_done == frames_total);
	repeat (4) @(posedge clk);
	if (got_q.size() == 0 && !out_valid_o)
	begin
		$display("No errors");
		$finish;
	end
	else
	begin
		abort_run("Output data remained after the last expected frame");
	end
end

endmodule

/* eth_tx_framer.f */
+incdir+hw
hw/axis_pkg.sv
hw/eth_pkg.sv
hw/axis_reg_slice.sv
hw/eth_framer_fsm.sv
hw/eth_hdr_beat_cnt.sv
hw/eth_beat_builder.sv
hw/eth_tx_framer.sv
dv/eth_tx_framer_tb.sv
